/* build.f */
design/stm_pkg.sv
design/stm_cmd_if.sv
design/stm_settings_decode.sv
design/stm_sync_track.sv
design/stm_swap_fsm.sv
design/stm_index_result.sv
design/stm_swapchain_top.sv
sim/stm_swap_checker.sv
sim/stm_swapchain_tb.sv

/* design/stm_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface stm_cmd_if;
  import stm_pkg::*;

  logic              cmd_valid;   // Single-cycle strobe, always accepted.
  cmd_kind_t         cmd_kind;
  logic              cmd_segment;
  logic [REP_W-1:0]  cmd_rep;
  logic [MODE_W-1:0] cmd_mode;
  logic [TIME_W-1:0] cmd_value;
  logic              cur_segment; // Segment now playing.

  modport decode (
    output cmd_valid, cmd_kind, cmd_segment, cmd_rep, cmd_mode, cmd_value,
    input  cur_segment
  );

  modport fsm (
    input  cmd_valid, cmd_kind, cmd_segment, cmd_rep, cmd_mode, cmd_value,
    output cur_segment
  );

endinterface

`default_nettype wire

/* design/stm_index_result.sv */
`timescale 1ns/1ps
`default_nettype none

module stm_index_result (
  input  logic                       CLK,
  input  logic                       rst_n,
  input  logic [stm_pkg::IDX_W-1:0]  cycle [2],
  input  logic [stm_pkg::IDX_W-1:0]  sync_idx_q [2],
  input  logic                       sync_changed [2],
  input  stm_pkg::idx_mode_t         idx_mode,
  input  logic                       cur_segment,
  input  logic [1:0]                 tic_clear,
  output logic                       tic_wrap [2],
  output logic [stm_pkg::IDX_W-1:0]  idx [2]
);
  import stm_pkg::*;

  logic [IDX_W-1:0] tic_cnt [2];

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      tic_wrap[s] = sync_changed[s] && (tic_cnt[s] == cycle[s]);
      idx[s]      = (idx_mode == IDX_MODE_SYNC_IDX) ? sync_idx_q[s] : tic_cnt[s];
    end
  end

  // Only the segment that is playing advances its counter.
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      tic_cnt[0] <= '0;
      tic_cnt[1] <= '0;
    end else begin
      for (int s = 0; s < 2; s++) begin
        if (tic_clear[s]) begin
          tic_cnt[s] <= '0;
        end else if (sync_changed[s] && (cur_segment == s[0])) begin
          tic_cnt[s] <= tic_wrap[s] ? '0 : tic_cnt[s] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/stm_pkg.sv */
`default_nettype none

package stm_pkg;

  localparam int IDX_W  = 16;
  localparam int REP_W  = 32;
  localparam int TIME_W = 64;
  localparam int MODE_W = 8;

  // A segment with this repeat count loops until the next swap request.
  localparam logic [REP_W-1:0] REP_INFINITE = '1;

  localparam logic [MODE_W-1:0] TRANSITION_MODE_SYNC_IDX = 8'h00;
  localparam logic [MODE_W-1:0] TRANSITION_MODE_SYS_TIME = 8'h01;
  localparam logic [MODE_W-1:0] TRANSITION_MODE_GPIO     = 8'h02;

  typedef enum logic {
    IDX_MODE_SYNC_IDX,
    IDX_MODE_TIC
  } idx_mode_t;

  typedef enum logic [1:0] {
    WAIT_START,
    FINITE_LOOP,
    INFINITE_LOOP
  } swap_state_t;

  typedef enum logic [1:0] {
    CMD_STAY,
    CMD_SWAP_NOW,
    CMD_ARM
  } cmd_kind_t;

endpackage

`default_nettype wire

/* design/stm_settings_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module stm_settings_decode (
  input  logic                        CLK,
  input  logic                        rst_n,
  input  logic                        update_settings,
  input  logic                        req_segment,
  input  logic [stm_pkg::MODE_W-1:0]  transition_mode,
  input  logic [stm_pkg::TIME_W-1:0]  transition_value,
  input  logic [stm_pkg::REP_W-1:0]   rep [2],
  stm_cmd_if.decode                   cmd
);
  import stm_pkg::*;

  cmd_kind_t        kind_next;
  logic [REP_W-1:0] rep_sel;

  assign rep_sel = rep[req_segment];

  // Classify the request against what is playing right now.
  always_comb begin
    if (req_segment == cmd.cur_segment) begin
      kind_next = CMD_STAY;
    end else if (rep_sel == REP_INFINITE) begin
      kind_next = CMD_SWAP_NOW;
    end else begin
      kind_next = CMD_ARM;
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      cmd.cmd_valid <= 1'b0;
    end else begin
      cmd.cmd_valid <= update_settings;
    end
  end

  always_ff @(posedge CLK) begin
    if (update_settings) begin
      cmd.cmd_kind    <= kind_next;
      cmd.cmd_segment <= req_segment;
      cmd.cmd_rep     <= rep_sel;
      cmd.cmd_mode    <= transition_mode;
      cmd.cmd_value   <= transition_value;
    end
  end

endmodule

`default_nettype wire

/* design/stm_swap_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module stm_swap_fsm #(
  parameter int NUM_GPIO = 4
) (
  input  logic                       CLK,
  input  logic                       rst_n,
  input  logic [stm_pkg::TIME_W-1:0] sys_time,
  input  logic [NUM_GPIO-1:0]        gpio_in,
  stm_cmd_if.fsm                     cmd,
  input  logic                       sync_changed [2],
  input  logic                       sync_wrap [2],
  input  logic                       tic_wrap [2],
  output stm_pkg::idx_mode_t         idx_mode,
  output logic [1:0]                 tic_clear,
  output logic                       stop
);
  import stm_pkg::*;

  localparam int GPIO_SEL_W = (NUM_GPIO > 1) ? $clog2(NUM_GPIO) : 1;

  swap_state_t       state;
  logic [REP_W-1:0]  loop_cnt;
  logic              arm_segment;
  logic [MODE_W-1:0] arm_mode;
  logic [TIME_W-1:0] arm_value;
  logic [REP_W-1:0]  arm_rep;
  logic [TIME_W-1:0] diff_value;
  logic [TIME_W:0]   time_diff;  // MSB set once time has passed the value.
  logic              event_hit;
  logic              tic_start;
  logic              fire;
  logic              loop_hit;

  // ----------------------------------------
  // Armed command and time difference
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (cmd.cmd_valid && (cmd.cmd_kind == CMD_ARM)) begin
      arm_segment <= cmd.cmd_segment;
      arm_mode    <= cmd.cmd_mode;
      arm_value   <= cmd.cmd_value;
      arm_rep     <= cmd.cmd_rep;
    end
  end

  // Follow a fresh command at once so a stale value never fires.
  assign diff_value = cmd.cmd_valid ? cmd.cmd_value : arm_value;

  always_ff @(posedge CLK) begin
    time_diff <= {1'b0, diff_value} - {1'b0, sys_time};
  end

  // ----------------------------------------
  // Transition events
  // ----------------------------------------
  always_comb begin
    event_hit = 1'b0;
    tic_start = 1'b1;
    case (arm_mode)
      TRANSITION_MODE_SYNC_IDX: begin
        event_hit = sync_wrap[arm_segment];
        tic_start = 1'b0;
      end
      TRANSITION_MODE_SYS_TIME: event_hit = time_diff[TIME_W];
      TRANSITION_MODE_GPIO: begin
        event_hit = sync_changed[arm_segment] && gpio_in[arm_value[GPIO_SEL_W-1:0]];
      end
      default: event_hit = 1'b0; // Unknown mode keeps waiting.
    endcase
  end

  assign fire      = (state == WAIT_START) && !cmd.cmd_valid && event_hit;
  assign tic_clear = (fire && tic_start) ? (2'b01 << arm_segment) : 2'b00;
  assign loop_hit  = (idx_mode == IDX_MODE_SYNC_IDX) ? sync_wrap[cmd.cur_segment]
                                                     : tic_wrap[cmd.cur_segment];

  // ----------------------------------------
  // Sequencer
  // ----------------------------------------
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state           <= INFINITE_LOOP;
      cmd.cur_segment <= 1'b0;
      idx_mode        <= IDX_MODE_SYNC_IDX;
      loop_cnt        <= '0;
      stop            <= 1'b0;
    end else if (cmd.cmd_valid) begin
      // A new command always replaces whatever was armed.
      if (cmd.cmd_kind == CMD_ARM) begin
        state <= WAIT_START;
      end else begin
        if (cmd.cmd_kind == CMD_SWAP_NOW) begin
          cmd.cur_segment <= cmd.cmd_segment;
        end
        state    <= INFINITE_LOOP;
        idx_mode <= IDX_MODE_SYNC_IDX;
        stop     <= 1'b0;
      end
    end else begin
      case (state)
        WAIT_START: begin
          if (fire) begin
            state           <= FINITE_LOOP;
            cmd.cur_segment <= arm_segment;
            idx_mode        <= tic_start ? IDX_MODE_TIC : IDX_MODE_SYNC_IDX;
            loop_cnt        <= '0;
            stop            <= 1'b0;
          end
        end
        FINITE_LOOP: begin
          if (loop_hit) begin
            if (loop_cnt == arm_rep) begin
              stop <= 1'b1;                  // Played rep + 1 times.
            end else begin
              loop_cnt <= loop_cnt + 1'b1;
            end
          end
        end
        default: state <= INFINITE_LOOP;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/stm_swapchain_top.sv */
`timescale 1ns/1ps
`default_nettype none

module stm_swapchain_top #(
  parameter int NUM_GPIO = 4
) (
  input  logic                       CLK,
  input  logic                       rst_n,
  input  logic [stm_pkg::TIME_W-1:0] sys_time,
  input  logic                       update_settings,
  input  logic                       req_segment,
  input  logic [stm_pkg::MODE_W-1:0] transition_mode,
  input  logic [stm_pkg::TIME_W-1:0] transition_value,
  input  logic [stm_pkg::IDX_W-1:0]  cycle0,
  input  logic [stm_pkg::IDX_W-1:0]  cycle1,
  input  logic [stm_pkg::REP_W-1:0]  rep0,
  input  logic [stm_pkg::REP_W-1:0]  rep1,
  input  logic [stm_pkg::IDX_W-1:0]  sync_idx0,
  input  logic [stm_pkg::IDX_W-1:0]  sync_idx1,
  input  logic [NUM_GPIO-1:0]        gpio_in,
  output logic                       stop,
  output logic                       segment,
  output logic [stm_pkg::IDX_W-1:0]  idx0,
  output logic [stm_pkg::IDX_W-1:0]  idx1
);
  import stm_pkg::*;

  logic [IDX_W-1:0] cycle [2];
  logic [REP_W-1:0] rep [2];
  logic [IDX_W-1:0] sync_idx [2];
  logic [IDX_W-1:0] sync_idx_q [2];
  logic [IDX_W-1:0] idx [2];
  logic             sync_changed [2];
  logic             sync_wrap [2];
  logic             tic_wrap [2];
  logic [1:0]       tic_clear;
  idx_mode_t        idx_mode;

  stm_cmd_if cmd_if ();

  assign cycle    = '{cycle0, cycle1};
  assign rep      = '{rep0, rep1};
  assign sync_idx = '{sync_idx0, sync_idx1};
  assign idx0     = idx[0];
  assign idx1     = idx[1];
  assign segment  = cmd_if.cur_segment;

  stm_settings_decode u_decode (
    .CLK(CLK), .rst_n(rst_n), .update_settings(update_settings),
    .req_segment(req_segment), .transition_mode(transition_mode),
    .transition_value(transition_value), .rep(rep), .cmd(cmd_if.decode)
  );

  stm_sync_track u_sync (
    .CLK(CLK), .rst_n(rst_n), .sync_idx(sync_idx), .sync_idx_q(sync_idx_q),
    .sync_changed(sync_changed), .sync_wrap(sync_wrap)
  );

  stm_swap_fsm #(.NUM_GPIO(NUM_GPIO)) u_fsm (
    .CLK(CLK), .rst_n(rst_n), .sys_time(sys_time), .gpio_in(gpio_in),
    .cmd(cmd_if.fsm), .sync_changed(sync_changed), .sync_wrap(sync_wrap),
    .tic_wrap(tic_wrap), .idx_mode(idx_mode), .tic_clear(tic_clear), .stop(stop)
  );

  stm_index_result u_result (
    .CLK(CLK), .rst_n(rst_n), .cycle(cycle), .sync_idx_q(sync_idx_q),
    .sync_changed(sync_changed), .idx_mode(idx_mode), .cur_segment(cmd_if.cur_segment),
    .tic_clear(tic_clear), .tic_wrap(tic_wrap), .idx(idx)
  );

endmodule

`default_nettype wire

/* design/stm_sync_track.sv */
`timescale 1ns/1ps
`default_nettype none

module stm_sync_track (
  input  logic                       CLK,
  input  logic                       rst_n,
  input  logic [stm_pkg::IDX_W-1:0]  sync_idx [2],
  output logic [stm_pkg::IDX_W-1:0]  sync_idx_q [2],
  output logic                       sync_changed [2],
  output logic                       sync_wrap [2]
);

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      sync_idx_q[0] <= '0;
      sync_idx_q[1] <= '0;
    end else begin
      sync_idx_q[0] <= sync_idx[0];
      sync_idx_q[1] <= sync_idx[1];
    end
  end

  // A wrap is a change that lands on index zero.
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      sync_changed[s] = (sync_idx[s] != sync_idx_q[s]);
      sync_wrap[s]    = sync_changed[s] && (sync_idx[s] == '0);
    end
  end

endmodule

`default_nettype wire

/* sim/stm_swap_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module stm_swap_checker (
  input logic                 CLK,
  input logic                 rst_n,
  input stm_pkg::swap_state_t state,
  input logic                 cmd_valid,
  input logic                 cur_segment,
  input logic                 stop
);
  import stm_pkg::*;

  // STOP is only ever set while a finite loop is playing.
  assert property (@(posedge CLK) disable iff (!rst_n) $rose(stop) |-> state == FINITE_LOOP)
    else $error("stop rose outside FINITE_LOOP");

  // The segment moves on a direct swap or when an armed transition fires.
  assert property (@(posedge CLK) disable iff (!rst_n)
    $changed(cur_segment) |-> $past(cmd_valid) || $past(cmd_valid, 2) ||
                              ($past(state) == WAIT_START && state != WAIT_START))
    else $error("cur_segment changed without a command or transition");

  assert property (@(posedge CLK) disable iff (!rst_n) cmd_valid |=> !cmd_valid)
    else $error("cmd_valid held for two cycles");

endmodule

bind stm_swap_fsm stm_swap_checker u_swap_checker (
  .CLK(CLK), .rst_n(rst_n), .state(state), .cmd_valid(cmd.cmd_valid),
  .cur_segment(cmd.cur_segment), .stop(stop)
);

`default_nettype wire

/* sim/stm_swapchain_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module stm_swapchain_tb;
  import stm_pkg::*;

  localparam int NUM_GPIO = 4;
  localparam int NUM_ROWS = 5;
  localparam int MAX_WAIT = 400;  // Cycles allowed for any single wait.
  localparam int STEP     = 3;    // Cycles between sync index steps.

  typedef struct {
    logic              seg;
    logic [MODE_W-1:0] mode;
    logic [TIME_W-1:0] value;     // Time offset in time mode, line number in GPIO mode.
    logic [REP_W-1:0]  rep;
    logic              exp_seg;
    logic              exp_stop;
    int                wraps;
  } row_t;

  logic CLK = 1'b0;
  logic rst_n, update_settings, req_segment, stop, segment;
  logic [TIME_W-1:0] sys_time, transition_value;
  logic [MODE_W-1:0] transition_mode;
  logic [IDX_W-1:0]  cyc [2];
  logic [IDX_W-1:0]  sidx [2];
  logic [REP_W-1:0]  rep0, rep1;
  logic [NUM_GPIO-1:0] gpio_in;
  logic [IDX_W-1:0]  idx0, idx1;
  logic [IDX_W-1:0]  prev_idx;
  int   chg_cnt [2];
  int   wrap_cnt [2];
  int   step_cnt, errors, seed, err_before, base, snap, n;
  row_t tests [NUM_ROWS];
  row_t t;
  logic old_seg;

  stm_swapchain_top #(.NUM_GPIO(NUM_GPIO)) DUT (
    .CLK(CLK), .rst_n(rst_n), .sys_time(sys_time), .update_settings(update_settings),
    .req_segment(req_segment), .transition_mode(transition_mode),
    .transition_value(transition_value), .cycle0(cyc[0]), .cycle1(cyc[1]),
    .rep0(rep0), .rep1(rep1), .sync_idx0(sidx[0]), .sync_idx1(sidx[1]),
    .gpio_in(gpio_in), .stop(stop), .segment(segment), .idx0(idx0), .idx1(idx1)
  );

  always #4 CLK = ~CLK;

  // ----------------------------------------
  // Sync index and system time models
  // ----------------------------------------
  always @(negedge CLK) begin
    if (rst_n) begin
      sys_time <= sys_time + 1'b1;
      step_cnt <= (step_cnt == STEP - 1) ? 0 : step_cnt + 1;
      if (step_cnt == STEP - 1) begin
        for (int s = 0; s < 2; s++) begin
          sidx[s]    <= (sidx[s] == cyc[s]) ? '0 : sidx[s] + 1'b1;
          chg_cnt[s] <= chg_cnt[s] + 1;
          if (sidx[s] == cyc[s]) wrap_cnt[s] <= wrap_cnt[s] + 1;
        end
      end
    end
  end

  task automatic report_mismatch(input string name, input longint exp, input longint got);
    $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, got);
    errors++;
  endtask

  // Let num wraps of the playing segment pass while stop must stay low.
  task automatic run_wraps(input int num);
    int start;
    int k;
    start = wrap_cnt[segment];
    k = 0;
    while (wrap_cnt[segment] - start < num && k < MAX_WAIT) begin
      @(posedge CLK);
      #1;
      if (stop !== 1'b0) report_mismatch("stop", 0, stop);
      k++;
    end
    if (k == MAX_WAIT) begin
      $display("Sync index model stopped wrapping at %0t", $time);
      errors++;
    end
  endtask

  initial begin : watchdog
    #(NUM_ROWS * 2 * MAX_WAIT * 8 + 2000);
    $display("Run stopped by the watchdog");
    $display("Finished with errors");
    $finish;
  end

  initial begin
    seed = 46;
    errors = 0;
    rst_n = 1'b0;
    update_settings = 1'b0;
    req_segment = 1'b0;
    transition_mode = '0;
    transition_value = '0;
    rep0 = REP_INFINITE;
    rep1 = REP_INFINITE;
    gpio_in = '0;
    sys_time = '0;
    step_cnt = 0;
    for (int s = 0; s < 2; s++) begin
      cyc[s] = 3 + ($unsigned($random(seed)) % 4);
      sidx[s] = '0;
      chg_cnt[s] = 0;
      wrap_cnt[s] = 0;
    end
    tests[0] = '{1'b0, TRANSITION_MODE_SYNC_IDX, 0, 2, 1'b0, 1'b0, 2};
    tests[1] = '{1'b1, TRANSITION_MODE_SYNC_IDX, 0, REP_INFINITE, 1'b1, 1'b0, 3};
    tests[2] = '{1'b0, TRANSITION_MODE_SYNC_IDX, 0, 1, 1'b0, 1'b1, 0};
    tests[3] = '{1'b1, TRANSITION_MODE_SYS_TIME, 40, 1, 1'b1, 1'b1, 0};
    tests[4] = '{1'b0, TRANSITION_MODE_GPIO, 2, 0, 1'b0, 1'b1, 0};
    repeat (5) @(negedge CLK);
    rst_n = 1'b1;

    // After reset the output index trails the external index by one cycle.
    if (stop !== 1'b0) report_mismatch("stop", 0, stop);
    if (segment !== 1'b0) report_mismatch("segment", 0, segment);
    repeat (12) begin
      @(posedge CLK);
      #1;
      if (idx0 !== sidx[0]) report_mismatch("idx0", sidx[0], idx0);
      prev_idx = sidx[0];
      @(negedge CLK);
      #1;
      if (idx0 !== prev_idx) report_mismatch("idx0", prev_idx, idx0);
    end

    for (int r = 0; r < NUM_ROWS; r++) begin
      t = tests[r];
      err_before = errors;
      @(negedge CLK);
      if (t.seg) rep1 = t.rep;
      else rep0 = t.rep;
      req_segment = t.seg;
      transition_mode = t.mode;
      transition_value = (t.mode == TRANSITION_MODE_SYS_TIME) ? sys_time + t.value : t.value;
      update_settings = 1'b1;
      old_seg = segment;
      @(negedge CLK);
      update_settings = 1'b0;
      gpio_in = '0;
      if (segment !== old_seg) report_mismatch("segment", old_seg, segment);
      if (t.seg == old_seg || t.rep == REP_INFINITE) begin
        @(posedge CLK);                     // Two edges after the update.
        #1;
        if (segment !== t.exp_seg) report_mismatch("segment", t.exp_seg, segment);
        run_wraps(t.wraps);
      end else begin
        if (t.mode == TRANSITION_MODE_GPIO) begin
          gpio_in = '1;                     // Every line but the selected one is high.
          gpio_in[t.value] = 1'b0;
          repeat (4 * STEP) begin
            @(posedge CLK);
            #1;
            if (segment !== old_seg) report_mismatch("segment", old_seg, segment);
          end
          snap = chg_cnt[t.seg];
          @(negedge CLK);
          gpio_in[t.value] = 1'b1;
        end
        n = 0;
        while (segment === old_seg && n < MAX_WAIT) begin
          @(posedge CLK);
          #1;
          n++;
        end
        if (n == MAX_WAIT) begin
          $display("Segment never changed in test %0d", r);
          errors++;
        end
        if (segment !== t.exp_seg) report_mismatch("segment", t.exp_seg, segment);
        if (t.mode == TRANSITION_MODE_SYNC_IDX && sidx[t.seg] != 0)
          report_mismatch("sync_idx", 0, sidx[t.seg]);
        // Time is seen past the value at one edge and the swap follows at the next.
        if (t.mode == TRANSITION_MODE_SYS_TIME && sys_time != transition_value + 2)
          report_mismatch("sys_time", transition_value + 2, sys_time);
        if (t.mode == TRANSITION_MODE_GPIO && chg_cnt[t.seg] - snap != 1)
          report_mismatch("sync changes with gpio high", 1, chg_cnt[t.seg] - snap);
        if (t.mode != TRANSITION_MODE_SYNC_IDX && (t.seg ? idx1 : idx0) != 0)
          report_mismatch("idx", 0, t.seg ? idx1 : idx0);
        base = (t.mode == TRANSITION_MODE_SYNC_IDX) ? wrap_cnt[t.seg] : chg_cnt[t.seg];
        n = 0;
        while (stop !== 1'b1 && n < MAX_WAIT) begin
          @(posedge CLK);
          #1;
          n++;
        end
        if (stop !== t.exp_stop) report_mismatch("stop", t.exp_stop, stop);
        if (t.mode == TRANSITION_MODE_SYNC_IDX) begin
          if (wrap_cnt[t.seg] - base != t.rep + 1)
            report_mismatch("wraps before stop", t.rep + 1, wrap_cnt[t.seg] - base);
        end else if (chg_cnt[t.seg] - base != (cyc[t.seg] + 1) * (t.rep + 1)) begin
          report_mismatch("sync changes before stop", (cyc[t.seg] + 1) * (t.rep + 1),
                          chg_cnt[t.seg] - base);
        end
      end
      $display("Test %0d %s", r, (errors == err_before) ? "passed" : "failed");
    end

    $display("Tests run: %0d, errors: %0d", NUM_ROWS, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
